/* all.f */
rtl/rv_pkg.sv
rtl/mem_wb_if.sv
rtl/data_ram.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/reg_file.sv
rtl/backend_top.sv
sim/tb_backend.sv

/* sim/tb_backend.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_backend import rv_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    // Directed, preload and random instruction count
    localparam int TOTAL_INSTS   = 84 + 16 + 200;
    // Extra cycles for reset and register sweeps
    localparam int MARGIN_CYCLES = 300;

    logic      clk;
    logic      rst;
    logic      exe_valid_i;
    word_t     exe_pc_i;
    inst_t     exe_inst_i;
    word_t     exe_result_i;
    word_t     exe_store_data_i;
    reg_addr_t rs1_addr_i;
    reg_addr_t rs2_addr_i;
    word_t     rs1_data_o;
    word_t     rs2_data_o;
    logic      retire_o;
    word_t     retire_pc_o;
    inst_t     retire_inst_o;

    // Reference model and bookkeeping
    word_t     model_regs [32];
    word_t     model_ram [DMEM_WORDS];
    word_t     pc_queue [$];
    inst_t     inst_queue [$];
    opcode_t   alu_ops [4] = '{OPC_LUI, OPC_AUIPC, OPC_OP, OPC_OP_IMM};
    word_t     run_pc = 32'h0000_1000;
    word_t     lfsr_state = 32'h9d43_ac02;
    int        issued_count = 0;
    int        retired_count = 0;
    int        error_count = 0;
    int        tests_passed = 0;
    int        tests_failed = 0;

    backend_top backend_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((TOTAL_INSTS + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before all tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic word_t lfsr_step(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic inst_t make_inst(opcode_t opc, funct3_t f3, reg_addr_t rd);
        return {17'd0, f3, rd, opc};
    endfunction

    // Retire pulses must follow issue order
    always @(negedge clk) begin
        if (retire_o === 1'b1) begin
            retired_count++;
            if (pc_queue.size() == 0) begin
                $display("Retire pulse at %0t with no instruction outstanding", $time);
                error_count++;
            end else begin
                check_word("retire_pc_o", retire_pc_o, pc_queue.pop_front());
                check_inst("retire_inst_o", retire_inst_o, inst_queue.pop_front());
            end
        end
    end

    // Register and RAM effect of one record in issue order
    task automatic model_apply(input word_t pc, input inst_t inst, input word_t res,
                               input word_t sdata);
        int    off;
        int    widx;
        word_t w;
        word_t value;
        logic  writes;
        off    = res[1:0];
        widx   = res[DMEM_AW+1:2];
        w      = model_ram[widx];
        value  = '0;
        writes = 1'b1;
        case (inst[6:0])
            OPC_LUI, OPC_AUIPC, OPC_OP, OPC_OP_IMM: value = res;
            OPC_JAL, OPC_JALR: value = pc + 32'd4;
            OPC_LOAD: begin
                case (inst[14:12])
                    F3_B:    value = {{24{w[8*off+7]}}, w[8*off +: 8]};
                    F3_BU:   value = {24'd0, w[8*off +: 8]};
                    F3_H:    value = {{16{w[16*(off/2)+15]}}, w[16*(off/2) +: 16]};
                    F3_HU:   value = {16'd0, w[16*(off/2) +: 16]};
                    default: value = w;
                endcase
            end
            default: writes = 1'b0;
        endcase
        if (inst[6:0] == OPC_STORE) begin
            case (inst[14:12])
                F3_B:    w[8*off +: 8] = sdata[7:0];
                F3_H:    w[16*(off/2) +: 16] = sdata[15:0];
                F3_W:    w = sdata;
                default: ;
            endcase
            model_ram[widx] = w;
        end
        if (writes && inst[11:7] != 5'd0) model_regs[inst[11:7]] = value;
    endtask

    // Drive one record for one cycle starting just after a rising edge
    task automatic issue(input inst_t inst, input word_t res, input word_t sdata);
        exe_valid_i      = 1'b1;
        exe_pc_i         = run_pc;
        exe_inst_i       = inst;
        exe_result_i     = res;
        exe_store_data_i = sdata;
        model_apply(run_pc, inst, res, sdata);
        pc_queue.push_back(run_pc);
        inst_queue.push_back(inst);
        issued_count++;
        run_pc = run_pc + 32'd4;
        @(posedge clk);
        #1;
        exe_valid_i = 1'b0;
    endtask

    // Last record retires in the next cycle and its write lands at the edge after that
    task automatic wait_drain();
        repeat (2) @(posedge clk);
        #1;
        check_word("retire count", word_t'(retired_count), word_t'(issued_count));
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < 32; i += 2) begin
            rs1_addr_i = reg_addr_t'(i);
            rs2_addr_i = reg_addr_t'(i + 1);
            #4;
            check_word($sformatf("rs1_data_o x%0d", i), rs1_data_o, model_regs[i]);
            check_word($sformatf("rs2_data_o x%0d", i + 1), rs2_data_o, model_regs[i + 1]);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("Test %s: passed", name);
            tests_passed++;
        end else begin
            $display("Test %s: FAILED with %0d errors", name, error_count - errors_before);
            tests_failed++;
        end
    endtask

    task automatic reset_state();
        int errs;
        errs = error_count;
        repeat (8) begin
            @(posedge clk);
            #1;
            check_bit("retire_o", retire_o, 1'b0);
        end
        rst = 1'b0;
        check_all_regs();
        report_test("reset state", errs);
    endtask

    // Retire two cycles after the strobe and register visible one cycle later
    task automatic alu_writeback();
        int    errs;
        word_t pc;
        word_t old;
        inst_t inst;
        errs = error_count;
        for (int k = 0; k < 4; k++) begin
            pc         = run_pc;
            old        = model_regs[k + 1];
            inst       = make_inst(alu_ops[k], F3_B, reg_addr_t'(k + 1));
            rs1_addr_i = reg_addr_t'(k + 1);
            issue(inst, {8'(k + 1), 24'hc0ffee}, '0);
            check_bit("retire_o", retire_o, 1'b0);
            @(posedge clk);
            #1;
            check_bit("retire_o", retire_o, 1'b1);
            check_word("retire_pc_o", retire_pc_o, pc);
            check_inst("retire_inst_o", retire_inst_o, inst);
            check_word("rs1_data_o", rs1_data_o, old);
            @(posedge clk);
            #1;
            check_bit("retire_o", retire_o, 1'b0);
            check_word("rs1_data_o", rs1_data_o, model_regs[k + 1]);
        end
        report_test("ALU write-back", errs);
    endtask

    task automatic jump_link();
        int errs;
        errs = error_count;
        issue(make_inst(OPC_JAL, F3_B, 5'd5), 32'hdead_beef, '0);
        issue(make_inst(OPC_JALR, F3_B, 5'd6), 32'h0bad_c0de, '0);
        wait_drain();
        check_all_regs();
        report_test("jumps", errs);
    endtask

    task automatic memory_access();
        int errs;
        errs = error_count;
        issue(make_inst(OPC_STORE, F3_W, 5'd0), 32'h200, 32'h8bad_f00d);
        issue(make_inst(OPC_STORE, F3_W, 5'd0), 32'h204, 32'h1122_3344);
        issue(make_inst(OPC_STORE, F3_H, 5'd0), 32'h208, 32'hffff_a5c3);
        issue(make_inst(OPC_STORE, F3_H, 5'd0), 32'h20a, 32'h0000_7e01);
        for (int off = 0; off < 4; off++) begin
            issue(make_inst(OPC_STORE, F3_B, 5'd0), 32'h20c + off, 32'habcd_ef7e + 32'h41 * off);
        end
        // Every lane of four words with signed and then unsigned loads
        for (int pass = 0; pass < 2; pass++) begin
            for (int off = 0; off < 16; off++) begin
                issue(make_inst(OPC_LOAD, pass ? F3_BU : F3_B, reg_addr_t'(1 + off)),
                      32'h200 + off, '0);
            end
            for (int off = 0; off < 16; off += 2) begin
                issue(make_inst(OPC_LOAD, pass ? F3_HU : F3_H, reg_addr_t'(17 + off / 2)),
                      32'h200 + off, '0);
            end
            for (int off = 0; off < 16; off += 4) begin
                issue(make_inst(OPC_LOAD, F3_W, reg_addr_t'(25 + off / 4)), 32'h200 + off, '0);
            end
            wait_drain();
            check_all_regs();
        end
        // Load directly behind a store to the same word
        issue(make_inst(OPC_STORE, F3_W, 5'd0), 32'h210, 32'hcafe_1234);
        issue(make_inst(OPC_LOAD, F3_B, 5'd1), 32'h213, '0);
        issue(make_inst(OPC_STORE, F3_B, 5'd0), 32'h201, 32'h0000_0055);
        issue(make_inst(OPC_LOAD, F3_W, 5'd2), 32'h200, '0);
        issue(make_inst(OPC_STORE, F3_H, 5'd0), 32'h212, 32'h0000_8001);
        issue(make_inst(OPC_LOAD, F3_HU, 5'd3), 32'h212, '0);
        wait_drain();
        check_all_regs();
        report_test("memory", errs);
    endtask

    task automatic non_writing();
        int errs;
        errs = error_count;
        issue(make_inst(OPC_BRANCH, F3_B, 5'd3), 32'h0000_0040, '0);
        issue(make_inst(OPC_STORE, F3_W, 5'd4), 32'h300, 32'h7777_8888);
        issue(make_inst(OPC_SYSTEM, F3_B, 5'd7), 32'h1111_2222, '0);
        issue(make_inst(7'b1111111, F3_B, 5'd8), 32'h3333_4444, '0);
        issue(make_inst(7'b0001011, F3_B, 5'd9), 32'h5555_6666, '0);
        issue(make_inst(OPC_OP, F3_B, 5'd0), 32'h9999_aaaa, '0);
        issue(make_inst(OPC_JAL, F3_B, 5'd0), '0, '0);
        issue(make_inst(OPC_LOAD, F3_W, 5'd0), 32'h200, '0);
        wait_drain();
        check_all_regs();
        report_test("non-writing", errs);
    endtask

    task automatic random_stream();
        int          errs;
        word_t       addr;
        word_t       sel;
        reg_addr_t   rd;
        opcode_t     opc;
        funct3_t     f3;
        logic [16:0] upper;
        errs = error_count;
        // Random loads only touch this preloaded region
        for (int k = 0; k < 16; k++) begin
            issue(make_inst(OPC_STORE, F3_W, 5'd0), 32'h400 + 4 * k, rand_bits(32));
        end
        for (int n = 0; n < 200; n++) begin
            rd    = reg_addr_t'(rand_bits(5));
            addr  = 32'h400 + rand_bits(6);
            upper = 17'(rand_bits(17));
            f3    = funct3_t'(rand_bits(3));
            case (rand_bits(2))
                2'd0: opc = alu_ops[rand_bits(2)];
                2'd1: opc = rand_bits(1) ? OPC_JALR : OPC_JAL;
                2'd2: begin
                    opc = OPC_STORE;
                    f3  = funct3_t'(rand_bits(2) % 3);
                end
                default: begin
                    opc = OPC_LOAD;
                    sel = rand_bits(3) % 5;
                    f3  = funct3_t'(sel < 3 ? sel : sel + 1);
                end
            endcase
            // Natural alignment for halves and words
            if (f3 == F3_H || f3 == F3_HU) addr[0] = 1'b0;
            if (f3 == F3_W) addr[1:0] = 2'b00;
            issue({upper, f3, rd, opc},
                  (opc == OPC_STORE || opc == OPC_LOAD) ? addr : rand_bits(32), rand_bits(32));
        end
        wait_drain();
        check_all_regs();
        report_test("random stream", errs);
    endtask

    initial begin
        rst              = 1'b1;
        exe_valid_i      = 1'b0;
        exe_pc_i         = '0;
        exe_inst_i       = '0;
        exe_result_i     = '0;
        exe_store_data_i = '0;
        rs1_addr_i       = '0;
        rs2_addr_i       = '0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++) model_ram[i] = '0;
        reset_state();
        alu_writeback();
        jump_link();
        memory_access();
        non_writing();
        random_stream();
        $display("Tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/backend_top.sv */
`timescale 1ns/1ns
`default_nettype none

module backend_top import rv_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    // Executed instruction from outside
    input  wire logic   exe_valid_i,
    input  word_t       exe_pc_i,
    input  inst_t       exe_inst_i,
    input  word_t       exe_result_i,
    input  word_t       exe_store_data_i,
    // Register read ports for the execute stage
    input  reg_addr_t   rs1_addr_i,
    input  reg_addr_t   rs2_addr_i,
    output word_t       rs1_data_o,
    output word_t       rs2_data_o,
    // Retire strobe
    output logic        retire_o,
    output word_t       retire_pc_o,
    output inst_t       retire_inst_o
);

    logic [DMEM_AW-1:0] ram_addr;
    logic [3:0]         ram_be;
    word_t              ram_wdata;
    word_t              ram_rdata;

    logic               rf_we;
    reg_addr_t          rf_waddr;
    word_t              rf_wdata;

    mem_wb_if mwb ();

    mem_stage u_mem_stage (
        .clk              (clk),
        .rst              (rst),
        .exe_valid_i      (exe_valid_i),
        .exe_pc_i         (exe_pc_i),
        .exe_inst_i       (exe_inst_i),
        .exe_result_i     (exe_result_i),
        .exe_store_data_i (exe_store_data_i),
        .ram_addr_o       (ram_addr),
        .ram_be_o         (ram_be),
        .ram_wdata_o      (ram_wdata),
        .mwb              (mwb.mem)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .addr_i  (ram_addr),
        .be_i    (ram_be),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    wb_stage u_wb_stage (
        .clk           (clk),
        .rst           (rst),
        .mwb           (mwb.wb),
        .ram_rdata_i   (ram_rdata),
        .rf_we_o       (rf_we),
        .rf_waddr_o    (rf_waddr),
        .rf_wdata_o    (rf_wdata),
        .retire_o      (retire_o),
        .retire_pc_o   (retire_pc_o),
        .retire_inst_o (retire_inst_o)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .raddr1_i (rs1_addr_i),
        .raddr2_i (rs2_addr_i),
        .rdata1_o (rs1_data_o),
        .rdata2_o (rs2_data_o)
    );

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file import rv_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    // Write port
    input  wire logic   we_i,
    input  reg_addr_t   waddr_i,
    input  word_t       wdata_i,
    // Asynchronous read ports
    input  reg_addr_t   raddr1_i,
    input  reg_addr_t   raddr2_i,
    output word_t       rdata1_o,
    output word_t       rdata2_o
);

    word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is hardwired to zero, no write bypass
    assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

/* rtl/wb_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_stage import rv_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    // Record from the memory stage
    mem_wb_if.wb        mwb,
    input  word_t       ram_rdata_i,
    // Register file write port
    output logic        rf_we_o,
    output reg_addr_t   rf_waddr_o,
    output word_t       rf_wdata_o,
    // Retire strobe for the fetch side
    output logic        retire_o,
    output word_t       retire_pc_o,
    output inst_t       retire_inst_o
);

    logic       valid_q;
    word_t      pc_q;
    inst_t      inst_q;
    word_t      result_q;
    word_t      rdata_q;

    opcode_t    opcode;
    funct3_t    funct3;
    logic [1:0] byte_off;
    logic [7:0] ld_byte;
    logic [15:0] ld_half;
    word_t      load_data;
    logic       writes_rd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mwb.valid;
        end
    end

    always_ff @(posedge clk) begin
        pc_q     <= mwb.pc;
        inst_q   <= mwb.inst;
        result_q <= mwb.result;
        rdata_q  <= ram_rdata_i;
    end

    assign opcode   = inst_q[6:0];
    assign funct3   = inst_q[14:12];
    assign byte_off = result_q[1:0];

    // Lane selected by the low address bits
    assign ld_byte = rdata_q[{byte_off, 3'b000} +: 8];
    assign ld_half = byte_off[1] ? rdata_q[31:16] : rdata_q[15:0];

    always_comb begin
        case (funct3)
            F3_B:    load_data = {{24{ld_byte[7]}}, ld_byte};
            F3_BU:   load_data = {24'd0, ld_byte};
            F3_H:    load_data = {{16{ld_half[15]}}, ld_half};
            F3_HU:   load_data = {16'd0, ld_half};
            default: load_data = rdata_q;
        endcase
    end

    // Write value and write decision per opcode
    always_comb begin
        writes_rd  = 1'b0;
        rf_wdata_o = result_q;
        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_OP, OPC_OP_IMM: begin
                writes_rd = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                writes_rd  = 1'b1;
                rf_wdata_o = pc_q + PC_STEP;
            end
            OPC_LOAD: begin
                writes_rd  = 1'b1;
                rf_wdata_o = load_data;
            end
            default: begin
                // Branch, store, system and unknown opcodes retire without writing
                writes_rd = 1'b0;
            end
        endcase
    end

    assign rf_waddr_o = inst_q[11:7];
    assign rf_we_o    = valid_q && writes_rd && (rf_waddr_o != 5'd0);

    assign retire_o      = valid_q;
    assign retire_pc_o   = pc_q;
    assign retire_inst_o = inst_q;

endmodule

`default_nettype wire

/* rtl/mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage import rv_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst,
    // Record from the execute stage
    input  wire logic                exe_valid_i,
    input  word_t                    exe_pc_i,
    input  inst_t                    exe_inst_i,
    input  word_t                    exe_result_i,
    input  word_t                    exe_store_data_i,
    // Data RAM port
    output logic [DMEM_AW-1:0]       ram_addr_o,
    output logic [3:0]               ram_be_o,
    output word_t                    ram_wdata_o,
    // Record towards write-back
    mem_wb_if.mem                    mwb
);

    opcode_t     opcode;
    funct3_t     funct3;
    logic [1:0]  byte_off;
    logic        is_store;

    assign opcode   = exe_inst_i[6:0];
    assign funct3   = exe_inst_i[14:12];
    assign byte_off = exe_result_i[1:0];
    assign is_store = exe_valid_i && (opcode == OPC_STORE);

    // Word address wraps modulo the RAM size
    assign ram_addr_o = exe_result_i[DMEM_AW+1:2];

    // Lane enables and replicated store data
    always_comb begin
        ram_be_o    = 4'b0000;
        ram_wdata_o = exe_store_data_i;
        case (funct3)
            F3_B: begin
                ram_wdata_o = {4{exe_store_data_i[7:0]}};
                if (is_store) begin
                    ram_be_o = 4'b0001 << byte_off;
                end
            end
            F3_H: begin
                ram_wdata_o = {2{exe_store_data_i[15:0]}};
                if (is_store) begin
                    ram_be_o = byte_off[1] ? 4'b1100 : 4'b0011;
                end
            end
            F3_W: begin
                if (is_store) begin
                    ram_be_o = 4'b1111;
                end
            end
            default: begin
                // Unsupported width, nothing is written
                ram_be_o = 4'b0000;
            end
        endcase
    end

    // Valid bit of the record
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mwb.valid <= 1'b0;
        end else begin
            mwb.valid <= exe_valid_i;
        end
    end

    // Payload, loaded only with a new instruction
    always_ff @(posedge clk) begin
        if (exe_valid_i) begin
            mwb.pc     <= exe_pc_i;
            mwb.inst   <= exe_inst_i;
            mwb.result <= exe_result_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/data_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module data_ram import rv_pkg::*; (
    input  wire logic               clk,
    input  wire logic [DMEM_AW-1:0] addr_i,
    input  wire logic [3:0]         be_i,
    input  word_t                   wdata_i,
    output word_t                   rdata_o
);

    word_t mem [DMEM_WORDS];

    // Byte lane writes
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (be_i[lane]) begin
                mem[addr_i][8*lane +: 8] <= wdata_i[8*lane +: 8];
            end
        end
    end

    // Registered read, old contents on a same-edge write
    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

/* rtl/mem_wb_if.sv */
`timescale 1ns/1ns
`default_nettype none

// One instruction record from the memory stage to write-back
interface mem_wb_if import rv_pkg::*; ();

    logic  valid;
    word_t pc;
    inst_t inst;
    // ALU result, or the memory address for loads and stores
    word_t result;

    modport mem (
        output valid,
        output pc,
        output inst,
        output result
    );

    modport wb (
        input valid,
        input pc,
        input inst,
        input result
    );

endinterface

`default_nettype wire

/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // Vector types with a meaning
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // RV32I major opcodes
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // Load and store width / sign field
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    // Link value offset for jumps
    localparam word_t PC_STEP = 32'd4;

    // Data RAM geometry, in 32-bit words
    localparam int DMEM_WORDS = 1024;
    localparam int DMEM_AW    = 10;

endpackage

`default_nettype wire
